//--- common/um245Pkg.sv
package um245Pkg;

    // host command opcodes, one command per cycle when valid
    typedef enum logic [1:0] {
        opNop    = 2'd0,
        opRxByte = 2'd1,  // byte arrives from the USB side
        opGrant  = 2'd2,  // allow data more bytes to be written by the CPU
        opTxPull = 2'd3   // take one written byte out of the tx FIFO
    } HostOp;

    // 11 bits
    typedef struct packed {
        logic       valid;
        HostOp      op;
        logic [7:0] data;
    } HostCmd;

    // answer to opTxPull, one cycle after the command
    typedef struct packed {
        logic       valid;
        logic       empty;  // tx FIFO had nothing to give
        logic [7:0] data;
    } HostResp;

    // single cycle error pulses
    typedef struct packed {
        logic badRead;     // rdN fell while rxfN high
        logic badWrite;    // wr fell while txeN high
        logic rxOverflow;  // opRxByte with rx FIFO full
    } PortErr;

    // default FIFO depth in bytes, power of two
    localparam int DefDepth = 16;

    // default recovery after a read or a write, in cycles
    localparam int DefRecover = 3;

    // transmit credit saturates here
    localparam logic [7:0] CreditMax = 8'hFF;

endpackage

//--- rtl/byteFifo.sv
module byteFifo #(
    parameter int Depth = um245Pkg::DefDepth
) (
    input  logic       _RD,
    input  logic       reset,
    input  logic       push,
    input  logic       pop,
    input  logic [7:0] pushData,
    output logic [7:0] headData,
    output logic       empty,
    output logic       full
);

    localparam int AddrW = $clog2(Depth);

    logic [7:0]     mem [Depth];
    logic [AddrW:0] wrPtr;  // extra msb tells full from empty
    logic [AddrW:0] rdPtr;
    logic           pushOk;
    logic           popOk;

    assign empty = (wrPtr == rdPtr);
    assign full  = (wrPtr[AddrW-1:0] == rdPtr[AddrW-1:0]) && (wrPtr[AddrW] != rdPtr[AddrW]);

    // drop illegal requests instead of corrupting the pointers
    assign pushOk = push && !full;
    assign popOk  = pop && !empty;

    // first word fall through, head always visible
    assign headData = mem[rdPtr[AddrW-1:0]];

    always_ff @(posedge _RD) begin
        if (reset) begin
            wrPtr <= '0;
            rdPtr <= '0;
        end else begin
            if (pushOk) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (popOk) begin
                rdPtr <= rdPtr + 1'b1;
            end
        end
    end

    always_ff @(posedge _RD) begin
        if (pushOk) begin
            mem[wrPtr[AddrW-1:0]] <= pushData;
        end
    end

    // the flag logic around each FIFO must keep these from happening
    pushNotFull: assert property (
        @(posedge _RD) disable iff (reset)
        push |-> !full
    ) else $error("byteFifo push while full");

    popNotEmpty: assert property (
        @(posedge _RD) disable iff (reset)
        pop |-> !empty
    ) else $error("byteFifo pop while empty");

endmodule

//--- um245/um245Port.sv
module um245Port #(
    parameter int RdRecover = um245Pkg::DefRecover,
    parameter int WrRecover = um245Pkg::DefRecover
) (
    input  logic              _RD,
    input  logic              reset,

    // CPU bus
    input  logic [7:0]        dataIn,
    input  logic              wr,
    input  logic              rdN,
    output logic [7:0]        dataOut,
    output logic              dataOe,
    output logic              txeN,
    output logic              rxfN,

    // FIFO side
    input  logic [7:0]        rxHead,
    input  logic              rxEmpty,
    input  logic              txFull,
    input  logic              txGrant,
    output logic              rxPop,
    output logic              txPush,
    output logic [7:0]        txData,

    output um245Pkg::PortErr  err
);

    localparam int RdCntW = $clog2(RdRecover + 1);
    localparam int WrCntW = $clog2(WrRecover + 1);

    logic              wrPrev;
    logic              rdNPrev;
    logic              wrFall;
    logic              rdFall;
    logic              rdRise;
    logic              readAccept;
    logic              readActive;  // between accepted rdN fall and its rise
    logic [RdCntW-1:0] rdCnt;
    logic [WrCntW-1:0] wrCnt;

    // previous samples of the strobes
    always_ff @(posedge _RD) begin
        if (reset) begin
            wrPrev  <= 1'b0;  // wr idles low
            rdNPrev <= 1'b1;  // rdN idles high
        end else begin
            wrPrev  <= wr;
            rdNPrev <= rdN;
        end
    end

    assign wrFall = wrPrev && !wr;
    assign rdFall = rdNPrev && !rdN;
    assign rdRise = !rdNPrev && rdN;

    assign readAccept = rdFall && !rxfN;

    // write strobe takes the byte in the same cycle
    assign txPush = wrFall && !txeN;
    assign txData = dataIn;

    // the byte leaves the FIFO only at the end of the read
    assign rxPop = readActive && rdRise;

    always_ff @(posedge _RD) begin
        if (reset) begin
            readActive <= 1'b0;
        end else if (readAccept) begin
            readActive <= 1'b1;
        end else if (rdRise) begin
            readActive <= 1'b0;
        end
    end

    assign dataOe  = readActive;
    assign dataOut = rxHead;

    // rx ready flag with read recovery
    always_ff @(posedge _RD) begin
        if (reset) begin
            rdCnt <= '0;
            rxfN  <= 1'b1;
        end else if (rxPop) begin
            rdCnt <= RdCntW'(RdRecover - 1);
            rxfN  <= 1'b1;
        end else if (rdCnt != '0) begin
            rdCnt <= rdCnt - 1'b1;
            rxfN  <= 1'b1;
        end else begin
            rxfN  <= rxEmpty;
        end
    end

    // tx ready flag needs credit, space and no recovery
    always_ff @(posedge _RD) begin
        if (reset) begin
            wrCnt <= '0;
            txeN  <= 1'b1;
        end else if (txPush) begin
            wrCnt <= WrCntW'(WrRecover - 1);
            txeN  <= 1'b1;
        end else if (wrCnt != '0) begin
            wrCnt <= wrCnt - 1'b1;
            txeN  <= 1'b1;
        end else begin
            txeN  <= !(txGrant && !txFull);
        end
    end

    // strobes against a busy flag move nothing
    assign err = '{
        badRead:    rdFall && rxfN,
        badWrite:   wrFall && txeN,
        rxOverflow: 1'b0
    };

    // an accepted write is followed by the full recovery window
    wrRecovery: assert property (
        @(posedge _RD) disable iff (reset)
        txPush |=> txeN [*WrRecover]
    ) else $error("um245Port write recovery broken");

    // bus is only driven when a byte is really there
    oeNeedsData: assert property (
        @(posedge _RD) disable iff (reset)
        $rose(dataOe) |-> !rxfN && !rxEmpty
    ) else $error("um245Port dataOe rose without data");

endmodule

//--- rtl/hostLink.sv
module hostLink (
    input  logic              _RD,
    input  logic              reset,
    input  um245Pkg::HostCmd  cmd,

    // rx FIFO write side
    output logic              rxPush,
    output logic [7:0]        rxData,
    input  logic              rxFull,

    // tx FIFO read side
    input  logic [7:0]        txHead,
    input  logic              txEmpty,
    output logic              txPop,

    input  logic              txPush,   // accepted CPU write, uses one credit
    output logic              txGrant,
    output um245Pkg::HostResp resp,
    output logic              rxOverflow
);

    import um245Pkg::*;

    logic       isRx;
    logic       isGrant;
    logic       isPull;
    logic [7:0] credit;
    logic [8:0] creditSum;
    logic       respValid;
    logic       respEmpty;
    logic [7:0] respData;

    always_comb begin
        isRx    = 1'b0;
        isGrant = 1'b0;
        isPull  = 1'b0;
        if (cmd.valid) begin
            case (cmd.op)
                opNop:    ;
                opRxByte: isRx    = 1'b1;
                opGrant:  isGrant = 1'b1;
                opTxPull: isPull  = 1'b1;
                default:  ;
            endcase
        end
    end

    assign rxPush     = isRx && !rxFull;
    assign rxOverflow = isRx && rxFull;  // byte is lost
    assign rxData     = cmd.data;

    assign txPop = isPull && !txEmpty;

    // grant and write may land in the same cycle
    assign creditSum = {1'b0, credit} + (isGrant ? {1'b0, cmd.data} : 9'd0) - {8'd0, txPush};

    always_ff @(posedge _RD) begin
        if (reset) begin
            credit <= '0;
        end else if (creditSum > {1'b0, CreditMax}) begin
            credit <= CreditMax;
        end else begin
            credit <= creditSum[7:0];
        end
    end

    assign txGrant = (credit != 8'd0);

    // pull answer one cycle after the command
    always_ff @(posedge _RD) begin
        if (reset) begin
            respValid <= 1'b0;
            respEmpty <= 1'b0;
        end else begin
            respValid <= isPull;
            respEmpty <= isPull && txEmpty;
        end
    end

    always_ff @(posedge _RD) begin
        respData <= txHead;
    end

    assign resp = '{valid: respValid, empty: respEmpty, data: respData};

    // port must never take a write without credit
    creditFloor: assert property (
        @(posedge _RD) disable iff (reset)
        txPush |-> credit != 8'd0
    ) else $error("hostLink credit would go below zero");

endmodule

//--- rtl/um245Bridge.sv
module um245Bridge #(
    parameter int Depth     = um245Pkg::DefDepth,
    parameter int RdRecover = um245Pkg::DefRecover,
    parameter int WrRecover = um245Pkg::DefRecover
) (
    input  logic              _RD,
    input  logic              reset,

    // CPU side
    input  logic [7:0]        dataIn,
    input  logic              wr,
    input  logic              rdN,
    output logic [7:0]        dataOut,
    output logic              dataOe,
    output logic              txeN,
    output logic              rxfN,

    // host side
    input  um245Pkg::HostCmd  hostCmd,
    output um245Pkg::HostResp hostResp,

    output um245Pkg::PortErr  portErr
);

    import um245Pkg::*;

    logic [7:0] rxHead;
    logic [7:0] rxData;
    logic       rxEmpty;
    logic       rxFull;
    logic       rxPush;
    logic       rxPop;
    logic [7:0] txHead;
    logic [7:0] txData;
    logic       txEmpty;
    logic       txFull;
    logic       txPush;
    logic       txPop;
    logic       txGrant;
    logic       rxOverflow;
    PortErr     cpuErr;  // strobe errors from the port

    um245Port #(
        .RdRecover (RdRecover),
        .WrRecover (WrRecover)
    ) u_um245Port (
        ._RD     (_RD),
        .reset   (reset),
        .dataIn  (dataIn),
        .wr      (wr),
        .rdN     (rdN),
        .dataOut (dataOut),
        .dataOe  (dataOe),
        .txeN    (txeN),
        .rxfN    (rxfN),
        .rxHead  (rxHead),
        .rxEmpty (rxEmpty),
        .txFull  (txFull),
        .txGrant (txGrant),
        .rxPop   (rxPop),
        .txPush  (txPush),
        .txData  (txData),
        .err     (cpuErr)
    );

    hostLink u_hostLink (
        ._RD        (_RD),
        .reset      (reset),
        .cmd        (hostCmd),
        .rxPush     (rxPush),
        .rxData     (rxData),
        .rxFull     (rxFull),
        .txHead     (txHead),
        .txEmpty    (txEmpty),
        .txPop      (txPop),
        .txPush     (txPush),
        .txGrant    (txGrant),
        .resp       (hostResp),
        .rxOverflow (rxOverflow)
    );

    // host to CPU
    byteFifo #(.Depth(Depth)) rxFifo (
        ._RD      (_RD),
        .reset    (reset),
        .push     (rxPush),
        .pop      (rxPop),
        .pushData (rxData),
        .headData (rxHead),
        .empty    (rxEmpty),
        .full     (rxFull)
    );

    // CPU to host
    byteFifo #(.Depth(Depth)) txFifo (
        ._RD      (_RD),
        .reset    (reset),
        .push     (txPush),
        .pop      (txPop),
        .pushData (txData),
        .headData (txHead),
        .empty    (txEmpty),
        .full     (txFull)
    );

    assign portErr = '{
        badRead:    cpuErr.badRead,
        badWrite:   cpuErr.badWrite,
        rxOverflow: rxOverflow
    };

endmodule

//--- verif/um245Checker.sv
module um245Checker #(
    parameter int Depth     = um245Pkg::DefDepth,
    parameter int RdRecover = um245Pkg::DefRecover,
    parameter int WrRecover = um245Pkg::DefRecover
) (
    input  logic              _RD,
    input  logic              reset,
    input  logic [7:0]        dataIn,
    input  logic              wr,
    input  logic              rdN,
    input  logic [7:0]        dataOut,
    input  logic              dataOe,
    input  logic              txeN,
    input  logic              rxfN,
    input  um245Pkg::HostCmd  hostCmd,
    input  um245Pkg::HostResp hostResp,
    input  um245Pkg::PortErr  portErr,
    output int                errCount,
    output int                checkCount
);

    timeunit 1ns;
    timeprecision 1ps;

    import um245Pkg::*;

    logic [7:0] rxQ[$];      // bytes the CPU has still to read
    logic [7:0] txQ[$];      // bytes the host has still to pull
    int         credit;
    int         rdHold;      // read recovery cycles left
    int         wrHold;
    logic       expRxfN;
    logic       expTxeN;
    logic       expOe;
    logic       expRespValid;
    logic       expRespEmpty;
    logic [7:0] expRespData;
    logic       prevWr;
    logic       prevRdN;
    logic       modelLive = 1'b0;  // high once a reset edge was seen
    int         errors = 0;
    int         checks = 0;

    assign errCount   = errors;
    assign checkCount = checks;

    task automatic compareBit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error at %0t: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    task automatic compareByte(input string name, input logic [7:0] exp, input logic [7:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    // outputs are settled at the falling edge, inputs are those of the next rising edge
    always @(negedge _RD) begin
        logic rdFall;
        logic rdRise;
        logic wrFall;
        logic isRx;
        logic isGrant;
        logic isPull;
        logic accRead;
        logic pop;
        logic push;
        logic rxFullNow;
        logic txFullNow;

        rdFall    = prevRdN && !rdN;
        rdRise    = !prevRdN && rdN;
        wrFall    = prevWr && !wr;
        isRx      = hostCmd.valid && (hostCmd.op == opRxByte);
        isGrant   = hostCmd.valid && (hostCmd.op == opGrant);
        isPull    = hostCmd.valid && (hostCmd.op == opTxPull);
        rxFullNow = (rxQ.size() == Depth);
        txFullNow = (txQ.size() == Depth);

        if (modelLive) begin
            compareBit("txeN", expTxeN, txeN);
            compareBit("rxfN", expRxfN, rxfN);
            compareBit("dataOe", expOe, dataOe);
            if (expOe && rxQ.size() > 0) begin
                compareByte("dataOut", rxQ[0], dataOut);
            end
            compareBit("hostResp.valid", expRespValid, hostResp.valid);
            if (expRespValid) begin
                compareBit("hostResp.empty", expRespEmpty, hostResp.empty);
                if (!expRespEmpty) begin
                    compareByte("hostResp.data", expRespData, hostResp.data);
                end
            end
            // strobes against a busy flag, and bytes into a full rx FIFO
            compareBit("portErr.badRead", rdFall && expRxfN, portErr.badRead);
            compareBit("portErr.badWrite", wrFall && expTxeN, portErr.badWrite);
            compareBit("portErr.rxOverflow", isRx && rxFullNow, portErr.rxOverflow);
        end

        if (reset) begin
            rxQ.delete();
            txQ.delete();
            credit       = 0;
            rdHold       = 0;
            wrHold       = 0;
            expRxfN      = 1'b1;
            expTxeN      = 1'b1;
            expOe        = 1'b0;
            expRespValid = 1'b0;
            expRespEmpty = 1'b0;
            expRespData  = 8'h00;
            prevWr       = 1'b0;
            prevRdN      = 1'b1;
            modelLive    = 1'b1;
        end else begin
            accRead = rdFall && !expRxfN;
            pop     = expOe && rdRise;   // a read ends when rdN comes back up
            push    = wrFall && !expTxeN;

            // flags for the next cycle use the FIFO levels before this edge
            if (pop) begin
                rdHold = RdRecover;
            end
            if (rdHold > 0) begin
                expRxfN = 1'b1;
                rdHold--;
            end else begin
                expRxfN = (rxQ.size() == 0);
            end
            if (push) begin
                wrHold = WrRecover;
            end
            if (wrHold > 0) begin
                expTxeN = 1'b1;
                wrHold--;
            end else begin
                expTxeN = !(credit > 0 && !txFullNow);
            end

            if (accRead) begin
                expOe = 1'b1;
            end else if (rdRise) begin
                expOe = 1'b0;
            end

            // pull sees the tx FIFO before a write of the same edge
            expRespValid = isPull;
            expRespEmpty = isPull && (txQ.size() == 0);
            if (isPull && txQ.size() > 0) begin
                expRespData = txQ.pop_front();
            end
            if (push && !txFullNow) begin
                txQ.push_back(dataIn);
            end
            if (pop) begin
                void'(rxQ.pop_front());
            end
            if (isRx && !rxFullNow) begin
                rxQ.push_back(hostCmd.data);
            end

            credit = credit + (isGrant ? int'(hostCmd.data) : 0) - (push ? 1 : 0);
            if (credit > 255) begin
                credit = 255;  // counter saturates
            end

            prevWr  = wr;
            prevRdN = rdN;
        end
    end

endmodule

//--- verif/um245Tb.sv
module um245Tb;

    timeunit 1ns;
    timeprecision 1ps;

    import um245Pkg::*;

    localparam int Depth     = DefDepth;
    localparam int RdRecover = DefRecover;
    localparam int WrRecover = 2;      // unlike RdRecover so the two windows differ
    localparam int NumCycles = 4000;
    localparam int ClkPeriod = 20;     // ns

    logic        _RD = 1'b0;
    logic        reset;
    logic [7:0]  dataIn;
    logic        wr;
    logic        rdN;
    logic [7:0]  dataOut;
    logic        dataOe;
    logic        txeN;
    logic        rxfN;
    HostCmd      hostCmd;
    HostResp     hostResp;
    PortErr      portErr;
    int          errCount;
    int          checkCount;

    logic [31:0] lcgState = 32'd88149;
    logic        seenTxeN = 1'b1;  // flags as they stood before the current edge
    logic        seenRxfN = 1'b1;
    int          rdHoldLeft = 0;

    always #(ClkPeriod / 2) _RD = ~_RD;

    um245Bridge #(
        .Depth     (Depth),
        .RdRecover (RdRecover),
        .WrRecover (WrRecover)
    ) u_um245Bridge (
        ._RD      (_RD),
        .reset    (reset),
        .dataIn   (dataIn),
        .wr       (wr),
        .rdN      (rdN),
        .dataOut  (dataOut),
        .dataOe   (dataOe),
        .txeN     (txeN),
        .rxfN     (rxfN),
        .hostCmd  (hostCmd),
        .hostResp (hostResp),
        .portErr  (portErr)
    );

    um245Checker #(
        .Depth     (Depth),
        .RdRecover (RdRecover),
        .WrRecover (WrRecover)
    ) u_checker (
        ._RD        (_RD),
        .reset      (reset),
        .dataIn     (dataIn),
        .wr         (wr),
        .rdN        (rdN),
        .dataOut    (dataOut),
        .dataOe     (dataOe),
        .txeN       (txeN),
        .rxfN       (rxfN),
        .hostCmd    (hostCmd),
        .hostResp   (hostResp),
        .portErr    (portErr),
        .errCount   (errCount),
        .checkCount (checkCount)
    );

    function logic [15:0] lcgNext();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState[31:16];
    endfunction

    always @(negedge _RD) begin
        seenTxeN <= txeN;
        seenRxfN <= rxfN;
    end

    // one host command per cycle, the mix shifts so both FIFOs fill and drain
    task automatic driveHost(input int cycle);
        logic [15:0] r;
        logic [15:0] d;
        int          rxWeight;
        HostCmd      c;
        r        = lcgNext();
        d        = lcgNext();
        rxWeight = ((cycle / 256) % 2 == 0) ? 6 : 2;
        c        = '0;
        c.valid  = 1'b1;
        c.data   = d[7:0];
        if (int'(r[3:0]) < rxWeight) begin
            c.op = opRxByte;
        end else if (int'(r[3:0]) < rxWeight + 2) begin
            c.op = opGrant;
            if (cycle >= NumCycles / 4) begin
                c.data = {6'd0, d[1:0]};  // small grants let the credit run dry
            end
        end else if (int'(r[3:0]) < rxWeight + 6) begin
            c.op = opTxPull;
        end else begin
            c.op    = opNop;
            c.valid = r[4];
        end
        hostCmd <= c;
    endtask

    // CPU strobes follow the flags except on about 1 in 16 attempts
    task automatic driveCpu();
        logic [15:0] rw;
        logic [15:0] rr;
        rw = lcgNext();
        rr = lcgNext();

        // write is a high pulse on wr, the byte is taken on the fall
        if (wr) begin
            if (!seenTxeN || rw[15:12] == 4'd0) begin
                wr     <= 1'b0;
                dataIn <= rw[7:0];
            end
        end else if (rw[9:8] == 2'd0) begin
            wr <= 1'b1;
        end

        if (rdHoldLeft > 0) begin
            rdHoldLeft--;
        end else if (!rdN) begin
            rdN        <= 1'b1;
            rdHoldLeft = 1;  // rxfN seen next cycle is still from before the pop
        end else if (rr[1:0] == 2'd0 && (!seenRxfN || rr[15:12] == 4'd0)) begin
            rdN        <= 1'b0;
            rdHoldLeft = int'(rr[3:2]);
        end
    endtask

    initial begin
        reset   = 1'b1;
        dataIn  = 8'h00;
        wr      = 1'b0;
        rdN     = 1'b1;
        hostCmd = '0;
        repeat (2) @(posedge _RD);
        reset <= 1'b0;
        for (int cycle = 0; cycle < NumCycles; cycle++) begin
            @(posedge _RD);
            driveHost(cycle);
            driveCpu();
        end
        @(posedge _RD);
        hostCmd <= '0;
        repeat (4) @(posedge _RD);
        $display("summary: %0d errors in %0d checks", errCount, checkCount);
        if (errCount == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // reset, the test cycles and the drain, with some room to spare
    initial begin
        #((NumCycles + 100) * ClkPeriod);
        $display("watchdog: the run did not finish in the expected time");
        $display("Done: errors found");
        $finish;
    end

endmodule

//--- vlog.f
common/um245Pkg.sv
rtl/byteFifo.sv
um245/um245Port.sv
rtl/hostLink.sv
rtl/um245Bridge.sv
verif/um245Checker.sv
verif/um245Tb.sv

//--- Makefile
# Verilator build and run for the UM245 bridge testbench

VERILATOR ?= verilator
TOP       ?= um245Tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Done: no errors$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
